// ==== Bender.yml ====
package:
  name: uart_console

export_include_dirs:
  - src

sources:
  - files:
      - src/uart_cmd_pkg.sv
      - src/baud_tick_gen.sv
      - src/uart_rx.sv
      - src/uart_tx.sv
      - src/cmd_decoder.sv
      - src/report_sender.sv
      - src/uart_console_top.sv
  - target: test
    files:
      - test/uart_console_assert.sv
      - test/uart_console_tb.sv

// ==== flist.f ====
+incdir+src
src/uart_cmd_pkg.sv
src/baud_tick_gen.sv
src/uart_rx.sv
src/uart_tx.sv
src/cmd_decoder.sv
src/report_sender.sv
src/uart_console_top.sv
test/uart_console_assert.sv
test/uart_console_tb.sv

// ==== src/baud_tick_gen.sv ====
`timescale 1ns/1ns
`include "uart_cmd_config.svh"

module baud_tick_gen (
    input  logic clk,
    input  logic rst,
    output logic tick
);
    localparam int TICK_DIV = `UART_TICK_DIV;
    localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(TICK_DIV - 1);

    logic [CNT_W-1:0] cnt_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt_q <= '0;
            tick  <= 1'b0;
        end else if (cnt_q == CNT_LAST) begin
            cnt_q <= '0;
            tick  <= 1'b1;
        end else begin
            cnt_q <= cnt_q + 1'b1;
            tick  <= 1'b0;
        end
    end

endmodule

// ==== src/cmd_decoder.sv ====
`timescale 1ns/1ns
`include "uart_cmd_config.svh"

module cmd_decoder (
    input  logic                       clk,
    input  logic                       rst,
    input  uart_cmd_pkg::uart_byte_t   rx_byte,
    output uart_cmd_pkg::console_cmd_t cmd,
    output logic                       report_req
);
    logic [3:0]                 btn_q;
    logic [3:0]                 sw_q;
    logic                       req_q;
    logic [`UART_DATA_BITS-1:0] sw_off;

    // bytes below '0' wrap to large values and miss the range check
    assign sw_off = rx_byte.data - `UART_DATA_BITS'(`KEY_SW0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            btn_q <= '0;
            sw_q  <= '0;
            req_q <= 1'b0;
        end else begin
            btn_q <= '0;
            req_q <= 1'b0;
            if (rx_byte.valid) begin
                case (rx_byte.data)
                    `KEY_R: btn_q <= 4'b0001;
                    `KEY_L: btn_q <= 4'b0010;
                    `KEY_U: btn_q <= 4'b0100;
                    `KEY_D: btn_q <= 4'b1000;
                    `KEY_S: req_q <= 1'b1;
                    default: begin
                        if (sw_off < `UART_DATA_BITS'(4)) begin
                            sw_q[sw_off[1:0]] <= ~sw_q[sw_off[1:0]];
                        end
                    end
                endcase
            end
        end
    end

    always_comb begin
        cmd.btn_tick = btn_q;
        cmd.sw_state = sw_q;
    end

    assign report_req = req_q;

endmodule

// ==== src/report_sender.sv ====
`timescale 1ns/1ns
`include "uart_cmd_config.svh"

module report_sender (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       report_req,
    input  uart_cmd_pkg::bcd_word_t    report_data,
    input  uart_cmd_pkg::report_mode_e report_mode,
    input  logic                       tx_ready,
    output uart_cmd_pkg::uart_byte_t   tx_char,
    output logic                       report_busy
);
    logic                       busy_q;
    logic                       valid_q;
    logic [2:0]                 idx_q;
    logic [2:0]                 last_idx;
    logic [`UART_DATA_BITS-1:0] char_d;
    uart_cmd_pkg::bcd_word_t    data_q;
    uart_cmd_pkg::report_mode_e mode_q;

    // anything outside 0..9 goes out as '0'
    function automatic logic [`UART_DATA_BITS-1:0] digit_char(input logic [3:0] digit);
        if (digit > 4'd9) begin
            return 8'h30;
        end
        return {4'h3, digit};
    endfunction

    assign last_idx = (mode_q == uart_cmd_pkg::MODE_SENSOR) ? 3'd5 : 3'd4;

    always_comb begin
        if (mode_q == uart_cmd_pkg::MODE_SENSOR) begin
            case (idx_q)
                3'd0:    char_d = digit_char(data_q.d3);
                3'd1:    char_d = digit_char(data_q.d2);
                3'd2:    char_d = digit_char(data_q.d1);
                3'd3:    char_d = digit_char(data_q.d0);
                3'd4:    char_d = 8'h63;
                default: char_d = 8'h6d;
            endcase
        end else begin
            case (idx_q)
                3'd0:    char_d = digit_char(data_q.d3);
                3'd1:    char_d = digit_char(data_q.d2);
                3'd2:    char_d = 8'h3a;
                3'd3:    char_d = digit_char(data_q.d1);
                default: char_d = digit_char(data_q.d0);
            endcase
        end
    end

    // idle, then offer a char, wait for ready, step the index
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy_q  <= 1'b0;
            valid_q <= 1'b0;
            idx_q   <= '0;
        end else if (!busy_q) begin
            if (report_req) begin
                busy_q <= 1'b1;
                idx_q  <= '0;
            end
        end else if (!valid_q) begin
            valid_q <= 1'b1;
        end else if (tx_ready) begin
            valid_q <= 1'b0;
            if (idx_q == last_idx) begin
                busy_q <= 1'b0;
            end else begin
                idx_q <= idx_q + 1'b1;
            end
        end
    end

    // snapshot so the report does not tear mid-transfer
    always_ff @(posedge clk) begin
        if (!busy_q && report_req) begin
            data_q <= report_data;
            mode_q <= report_mode;
        end
    end

    always_comb begin
        tx_char.valid = valid_q;
        tx_char.data  = char_d;
    end

    assign report_busy = busy_q;

endmodule

// ==== src/uart_cmd_config.svh ====
`ifndef UART_CMD_CONFIG_SVH
`define UART_CMD_CONFIG_SVH

// system clock and serial line rates
`define UART_CLK_HZ      10_000_000
`define UART_BAUD        312_500
`define UART_OVERSAMPLE  16

// clock cycles per oversampling tick
`define UART_TICK_DIV    (`UART_CLK_HZ / (`UART_BAUD * `UART_OVERSAMPLE))

`define UART_DATA_BITS   8

// console keys, ascii
`define KEY_R            8'h72
`define KEY_L            8'h6c
`define KEY_U            8'h75
`define KEY_D            8'h64
`define KEY_S            8'h73
// '1' to '3' follow in sequence
`define KEY_SW0          8'h30

`endif

// ==== src/uart_cmd_pkg.sv ====
`include "uart_cmd_config.svh"

package uart_cmd_pkg;

    // one byte on the rx or tx side, valid qualifies data
    typedef struct packed {
        logic                       valid;
        logic [`UART_DATA_BITS-1:0] data;
    } uart_byte_t;

    // btn_tick bit 0 is r, then l, u, d
    typedef struct packed {
        logic [3:0] btn_tick;
        logic [3:0] sw_state;
    } console_cmd_t;

    // clock mode d3 d2 : d1 d0, sensor mode d3 d2 d1 d0 cm
    typedef enum logic {
        MODE_CLOCK  = 1'b0,
        MODE_SENSOR = 1'b1
    } report_mode_e;

    // four bcd digits, d3 most significant
    typedef struct packed {
        logic [3:0] d3;
        logic [3:0] d2;
        logic [3:0] d1;
        logic [3:0] d0;
    } bcd_word_t;

endpackage

// ==== src/uart_console_top.sv ====
`timescale 1ns/1ns

module uart_console_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       uart_rx_line,
    input  uart_cmd_pkg::bcd_word_t    report_data,
    input  uart_cmd_pkg::report_mode_e report_mode,
    output logic                       uart_tx_line,
    output uart_cmd_pkg::console_cmd_t cmd,
    output logic                       report_busy
);
    logic                     tick;
    logic                     report_req;
    logic                     tx_ready;
    uart_cmd_pkg::uart_byte_t rx_byte;
    uart_cmd_pkg::uart_byte_t tx_char;

    // one tick shared by both directions
    baud_tick_gen u_tick (
        .clk  (clk),
        .rst  (rst),
        .tick (tick)
    );

    uart_rx u_rx (
        .clk     (clk),
        .rst     (rst),
        .tick    (tick),
        .rx_line (uart_rx_line),
        .rx_byte (rx_byte)
    );

    cmd_decoder u_decoder (
        .clk        (clk),
        .rst        (rst),
        .rx_byte    (rx_byte),
        .cmd        (cmd),
        .report_req (report_req)
    );

    report_sender u_sender (
        .clk         (clk),
        .rst         (rst),
        .report_req  (report_req),
        .report_data (report_data),
        .report_mode (report_mode),
        .tx_ready    (tx_ready),
        .tx_char     (tx_char),
        .report_busy (report_busy)
    );

    uart_tx u_tx (
        .clk      (clk),
        .rst      (rst),
        .tick     (tick),
        .tx_char  (tx_char),
        .tx_line  (uart_tx_line),
        .tx_ready (tx_ready)
    );

endmodule

// ==== src/uart_rx.sv ====
`timescale 1ns/1ns
`include "uart_cmd_config.svh"

module uart_rx (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    tick,
    input  logic                    rx_line,
    output uart_cmd_pkg::uart_byte_t rx_byte
);
    localparam int OS = `UART_OVERSAMPLE;
    localparam int NB = `UART_DATA_BITS;
    localparam int CNT_W = $clog2(OS);
    localparam int BIT_W = $clog2(NB);
    localparam logic [CNT_W-1:0] HALF_TICK = CNT_W'(OS / 2 - 1);
    localparam logic [CNT_W-1:0] LAST_TICK = CNT_W'(OS - 1);
    localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(NB - 1);

    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_START = 2'd1;
    localparam logic [1:0] S_DATA  = 2'd2;
    localparam logic [1:0] S_STOP  = 2'd3;

    logic [1:0]       state_q;
    logic [1:0]       rx_sync_q;
    logic             rx_in;
    logic [CNT_W-1:0] tick_cnt_q;
    logic [BIT_W-1:0] bit_cnt_q;
    logic [NB-1:0]    shift_q;
    logic             valid_q;

    // line idles high, so the synchronizer resets high
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rx_sync_q <= 2'b11;
        end else begin
            rx_sync_q <= {rx_sync_q[0], rx_line};
        end
    end

    assign rx_in = rx_sync_q[1];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q    <= S_IDLE;
            tick_cnt_q <= '0;
            bit_cnt_q  <= '0;
            valid_q    <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    tick_cnt_q <= '0;
                    bit_cnt_q  <= '0;
                    if (tick && !rx_in) begin
                        state_q <= S_START;
                    end
                end
                S_START: begin
                    if (tick) begin
                        if (tick_cnt_q == HALF_TICK) begin
                            tick_cnt_q <= '0;
                            // glitch shorter than half a bit goes back to idle
                            state_q    <= rx_in ? S_IDLE : S_DATA;
                        end else begin
                            tick_cnt_q <= tick_cnt_q + 1'b1;
                        end
                    end
                end
                S_DATA: begin
                    if (tick) begin
                        if (tick_cnt_q == LAST_TICK) begin
                            tick_cnt_q <= '0;
                            if (bit_cnt_q == LAST_BIT) begin
                                state_q <= S_STOP;
                            end else begin
                                bit_cnt_q <= bit_cnt_q + 1'b1;
                            end
                        end else begin
                            tick_cnt_q <= tick_cnt_q + 1'b1;
                        end
                    end
                end
                default: begin
                    if (tick) begin
                        if (tick_cnt_q == LAST_TICK) begin
                            state_q <= S_IDLE;
                            // framing error drops the byte
                            valid_q <= rx_in;
                        end else begin
                            tick_cnt_q <= tick_cnt_q + 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    // lsb first
    always_ff @(posedge clk) begin
        if (state_q == S_DATA && tick && tick_cnt_q == LAST_TICK) begin
            shift_q <= {rx_in, shift_q[NB-1:1]};
        end
    end

    always_comb begin
        rx_byte.valid = valid_q;
        rx_byte.data  = shift_q;
    end

endmodule

// ==== src/uart_tx.sv ====
`timescale 1ns/1ns
`include "uart_cmd_config.svh"

module uart_tx (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     tick,
    input  uart_cmd_pkg::uart_byte_t tx_char,
    output logic                     tx_line,
    output logic                     tx_ready
);
    localparam int OS = `UART_OVERSAMPLE;
    localparam int NB = `UART_DATA_BITS;
    localparam int CNT_W = $clog2(OS);
    localparam int BIT_W = $clog2(NB);
    localparam logic [CNT_W-1:0] LAST_TICK = CNT_W'(OS - 1);
    localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(NB - 1);

    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_START = 2'd1;
    localparam logic [1:0] S_DATA  = 2'd2;
    localparam logic [1:0] S_STOP  = 2'd3;

    logic [1:0]       state_q;
    logic [CNT_W-1:0] tick_cnt_q;
    logic [BIT_W-1:0] bit_cnt_q;
    logic [NB-1:0]    shift_q;
    logic             line_q;
    logic             bit_end;

    assign bit_end  = tick && (tick_cnt_q == LAST_TICK);
    assign tx_ready = (state_q == S_IDLE);
    assign tx_line  = line_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q    <= S_IDLE;
            tick_cnt_q <= '0;
            bit_cnt_q  <= '0;
            line_q     <= 1'b1;
        end else begin
            if (state_q != S_IDLE && tick) begin
                tick_cnt_q <= tick_cnt_q + 1'b1;
            end
            case (state_q)
                S_IDLE: begin
                    tick_cnt_q <= '0;
                    bit_cnt_q  <= '0;
                    if (tx_char.valid) begin
                        state_q <= S_START;
                        line_q  <= 1'b0;
                    end
                end
                S_START: begin
                    if (bit_end) begin
                        state_q <= S_DATA;
                        line_q  <= shift_q[0];
                    end
                end
                S_DATA: begin
                    if (bit_end) begin
                        if (bit_cnt_q == LAST_BIT) begin
                            state_q <= S_STOP;
                            line_q  <= 1'b1;
                        end else begin
                            bit_cnt_q <= bit_cnt_q + 1'b1;
                            line_q    <= shift_q[1];
                        end
                    end
                end
                default: begin
                    if (bit_end) begin
                        state_q <= S_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == S_IDLE && tx_char.valid) begin
            shift_q <= tx_char.data;
        end else if (state_q == S_DATA && bit_end) begin
            shift_q <= shift_q >> 1;
        end
    end

endmodule

// ==== test/uart_console_assert.sv ====
`timescale 1ns/1ns

module uart_console_assert (
    input logic                       clk,
    input logic                       rst,
    input uart_cmd_pkg::uart_byte_t   tx_char,
    input logic                       tx_ready,
    input logic                       tx_line,
    input uart_cmd_pkg::console_cmd_t cmd
);
    int fail_count = 0;

    // offered char held until the transmitter takes it
    assert property (@(posedge clk) disable iff (rst)
        (tx_char.valid && !tx_ready) |=> (tx_char.valid && $stable(tx_char.data)))
    else begin
        fail_count++;
        $error("tx_char changed or dropped before its transfer");
    end

    // low line means a frame is going out
    assert property (@(posedge clk) disable iff (rst) !tx_line |-> !tx_ready)
    else begin
        fail_count++;
        $error("tx_ready high while the transmitter drives a low bit");
    end

    assert property (@(posedge clk) disable iff (rst)
        (cmd.btn_tick != 4'b0000) |=> (cmd.btn_tick == 4'b0000))
    else begin
        fail_count++;
        $error("btn_tick held for more than one cycle");
    end

endmodule

bind uart_console_top uart_console_assert assert_i (
    .clk      (clk),
    .rst      (rst),
    .tx_char  (tx_char),
    .tx_ready (tx_ready),
    .tx_line  (uart_tx_line),
    .cmd      (cmd)
);

// ==== test/uart_console_tb.sv ====
`timescale 1ns/1ns
`include "uart_cmd_config.svh"

module uart_console_tb;
    localparam int BIT_CYCLES = `UART_OVERSAMPLE * `UART_TICK_DIV;
    localparam int FRAME_CYCLES = BIT_CYCLES * (`UART_DATA_BITS + 2);
    // about 33 frames plus idle gaps, doubled for margin
    localparam int FRAME_SLOTS = 62;
    localparam int MAX_CYCLES = FRAME_SLOTS * FRAME_CYCLES * 2;
    localparam int NUM_TESTS = 6;

    logic                       clk;
    logic                       rst;
    logic                       uart_rx_line;
    uart_cmd_pkg::bcd_word_t    report_data;
    uart_cmd_pkg::report_mode_e report_mode;
    logic                       uart_tx_line;
    uart_cmd_pkg::console_cmd_t cmd;
    logic                       report_busy;

    int errors = 0;
    int cycles = 0;
    int tests_failed = 0;
    uart_cmd_pkg::console_cmd_t cmd_pulses[$];
    logic [7:0] exp_chars[$];

    uart_console_top dut_i (
        .clk          (clk),
        .rst          (rst),
        .uart_rx_line (uart_rx_line),
        .report_data  (report_data),
        .report_mode  (report_mode),
        .uart_tx_line (uart_tx_line),
        .cmd          (cmd),
        .report_busy  (report_busy)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("run stopped after %0d cycles without finishing", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    // every cycle with a button bit set
    always @(posedge clk) begin
        if (!rst && cmd.btn_tick != 4'b0000) begin
            cmd_pulses.push_back(cmd);
        end
    end

    task automatic check_cmd(input string name, input uart_cmd_pkg::console_cmd_t got,
                             input uart_cmd_pkg::console_cmd_t exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_char(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s got %b expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    // serial monitor, compares each char against the expected queue
    initial begin : tx_monitor
        logic [7:0] rx_char;
        forever begin
            @(posedge clk);
            if (!rst && uart_tx_line == 1'b0) begin
                repeat (BIT_CYCLES / 2) @(posedge clk);
                for (int i = 0; i < `UART_DATA_BITS; i++) begin
                    repeat (BIT_CYCLES) @(posedge clk);
                    rx_char[i] = uart_tx_line;
                end
                repeat (BIT_CYCLES) @(posedge clk);
                if (uart_tx_line !== 1'b1) begin
                    $display("missing stop bit on uart_tx_line at %0t", $time);
                    errors++;
                end
                if (exp_chars.size() == 0) begin
                    $display("unexpected character %h on uart_tx_line at %0t", rx_char, $time);
                    errors++;
                end else begin
                    check_char("uart_tx_line", rx_char, exp_chars.pop_front());
                end
            end
        end
    end

    task automatic advance_cycle();
        @(posedge clk);
        #10;
    endtask

    // 8N1, lsb first
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            uart_rx_line = frame[i];
            repeat (BIT_CYCLES) advance_cycle();
        end
    endtask

    task automatic wait_busy(input logic level, input int limit);
        int n;
        n = 0;
        while (report_busy !== level && n < limit) begin
            advance_cycle();
            n++;
        end
        if (report_busy !== level) begin
            $display("report_busy did not go to %b within %0d cycles", level, limit);
            errors++;
        end
    endtask

    task automatic wait_chars_drained(input int limit);
        int n;
        n = 0;
        while (exp_chars.size() != 0 && n < limit) begin
            advance_cycle();
            n++;
        end
        if (exp_chars.size() != 0) begin
            $display("%0d report characters never arrived", exp_chars.size());
            errors++;
        end
    endtask

    function automatic logic [7:0] digit_ascii(input logic [3:0] d);
        if (d > 4'd9) begin
            return "0";
        end
        return "0" + 8'(d);
    endfunction

    function automatic string expected_report(input uart_cmd_pkg::bcd_word_t w,
                                              input uart_cmd_pkg::report_mode_e m);
        if (m == uart_cmd_pkg::MODE_CLOCK) begin
            return $sformatf("%c%c:%c%c", digit_ascii(w.d3), digit_ascii(w.d2),
                             digit_ascii(w.d1), digit_ascii(w.d0));
        end
        return $sformatf("%c%c%c%ccm", digit_ascii(w.d3), digit_ascii(w.d2),
                         digit_ascii(w.d1), digit_ascii(w.d0));
    endfunction

    task automatic expect_report(input uart_cmd_pkg::bcd_word_t w,
                                 input uart_cmd_pkg::report_mode_e m);
        string text;
        text = expected_report(w, m);
        for (int i = 0; i < text.len(); i++) begin
            exp_chars.push_back(text[i]);
        end
    endtask

    function automatic uart_cmd_pkg::bcd_word_t random_digits();
        uart_cmd_pkg::bcd_word_t w;
        w.d3 = 4'($urandom_range(9, 0));
        w.d2 = 4'($urandom_range(9, 0));
        w.d1 = 4'($urandom_range(9, 0));
        w.d0 = 4'($urandom_range(9, 0));
        return w;
    endfunction

    // one report from key s to the last char on the line
    task automatic run_report(input uart_cmd_pkg::bcd_word_t w,
                              input uart_cmd_pkg::report_mode_e m);
        report_data = w;
        report_mode = m;
        expect_report(w, m);
        send_byte(`KEY_S);
        check_bit("report_busy", report_busy, 1'b1);
        wait_busy(1'b0, 8 * FRAME_CYCLES);
        // busy drops once the last char is taken, before it is on the line
        if (exp_chars.size() != 1) begin
            $display("report_busy fell with %0d characters still due", exp_chars.size());
            errors++;
        end
        wait_chars_drained(2 * FRAME_CYCLES);
        check_bit("report_busy", report_busy, 1'b0);
    endtask

    task automatic finish_test(input string name, input int mark);
        if (errors == mark) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - mark);
            tests_failed++;
        end
    endtask

    initial begin
        uart_cmd_pkg::console_cmd_t exp_cmd;
        uart_cmd_pkg::console_cmd_t pulse_exp;
        uart_cmd_pkg::bcd_word_t    word;
        logic [7:0]                 keys[4];
        int                         order[4];
        int                         j;
        int                         tmp;
        int                         mark;
        clk = 1'b0;
        rst = 1'b1;
        uart_rx_line = 1'b1;
        report_data = '0;
        report_mode = uart_cmd_pkg::MODE_CLOCK;
        void'($urandom(56626));
        repeat (3) @(posedge clk);
        #10;
        rst = 1'b0;

        mark = errors;
        exp_cmd = '0;
        advance_cycle();
        check_bit("uart_tx_line", uart_tx_line, 1'b1);
        check_cmd("cmd", cmd, exp_cmd);
        check_bit("report_busy", report_busy, 1'b0);
        finish_test("1 reset state", mark);

        mark = errors;
        keys = '{`KEY_R, `KEY_L, `KEY_U, `KEY_D};
        for (int i = 0; i < 4; i++) begin
            cmd_pulses.delete();
            send_byte(keys[i]);
            pulse_exp.btn_tick = 4'b0001 << i;
            pulse_exp.sw_state = exp_cmd.sw_state;
            if (cmd_pulses.size() != 1) begin
                $display("key %c gave %0d button cycles instead of one", keys[i],
                         cmd_pulses.size());
                errors++;
            end else begin
                check_cmd("cmd", cmd_pulses[0], pulse_exp);
            end
            check_cmd("cmd", cmd, exp_cmd);
        end
        cmd_pulses.delete();
        send_byte("x");
        if (cmd_pulses.size() != 0) begin
            $display("key x raised a button bit");
            errors++;
        end
        check_cmd("cmd", cmd, exp_cmd);
        finish_test("2 buttons", mark);

        // two rounds of shuffled switch keys, second round restores
        mark = errors;
        order = '{0, 1, 2, 3};
        for (int round = 0; round < 2; round++) begin
            for (int i = 3; i > 0; i--) begin
                j = $urandom_range(i, 0);
                tmp = order[i];
                order[i] = order[j];
                order[j] = tmp;
            end
            for (int i = 0; i < 4; i++) begin
                send_byte(8'(`KEY_SW0 + order[i]));
                exp_cmd.sw_state[order[i]] = ~exp_cmd.sw_state[order[i]];
                check_cmd("cmd", cmd, exp_cmd);
            end
        end
        finish_test("3 switches", mark);

        mark = errors;
        run_report(random_digits(), uart_cmd_pkg::MODE_CLOCK);
        finish_test("4 clock report", mark);

        mark = errors;
        word = random_digits();
        case ($urandom_range(3, 0))
            0: word.d3 = 4'($urandom_range(15, 10));
            1: word.d2 = 4'($urandom_range(15, 10));
            2: word.d1 = 4'($urandom_range(15, 10));
            default: word.d0 = 4'($urandom_range(15, 10));
        endcase
        run_report(word, uart_cmd_pkg::MODE_SENSOR);
        finish_test("5 sensor report", mark);

        mark = errors;
        word = random_digits();
        report_data = word;
        report_mode = uart_cmd_pkg::MODE_CLOCK;
        expect_report(word, uart_cmd_pkg::MODE_CLOCK);
        send_byte(`KEY_S);
        check_bit("report_busy", report_busy, 1'b1);
        send_byte(`KEY_S);
        check_bit("report_busy", report_busy, 1'b1);
        wait_busy(1'b0, 8 * FRAME_CYCLES);
        wait_chars_drained(2 * FRAME_CYCLES);
        // a second report would show up here
        repeat (2 * FRAME_CYCLES) advance_cycle();
        check_bit("report_busy", report_busy, 1'b0);
        finish_test("6 request while busy", mark);

        errors = errors + dut_i.assert_i.fail_count;
        $display("%0d tests, %0d failed, %0d errors, %0d assertion failures", NUM_TESTS,
                 tests_failed, errors, dut_i.assert_i.fail_count);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
